// File: src/operand_cfg.svh
`ifndef OPERAND_CFG_SVH
`define OPERAND_CFG_SVH

// Width of one integer register and of every operand value
`define OPS_XLEN 32

// Number of architectural integer registers including x0
`define OPS_NREGS 32

// Bits needed to name one register in rs1, rs2 or rd
`define OPS_RADDR_W 5

`endif

// File: src/pipe_pkg.sv
package pipe_pkg;

    // Instruction class as seen by the operand supply logic
    // NOP is what a bubble carries through EX and MEM
    typedef enum logic [3:0] {
        NOP    = 4'd0,
        LUI    = 4'd1,
        AUIPC  = 4'd2,
        I_TYPE = 4'd3,
        R_TYPE = 4'd4,
        LOAD   = 4'd5,
        STORE  = 4'd6,
        JAL    = 4'd7,
        JALR   = 4'd8,
        BRANCH = 4'd9
    } ir_type_e;

    // Source of one ID operand
    // FWD_EX takes C of the instruction in EX
    // FWD_MEM takes the write-back value of the instruction in MEM
    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_EX   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_e;

endpackage

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "operand_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`OPS_RADDR_W-1:0] raddr1,
    input  logic [`OPS_RADDR_W-1:0] raddr2,
    output logic [`OPS_XLEN-1:0]    rdata1,
    output logic [`OPS_XLEN-1:0]    rdata2,
    input  logic                    we,
    input  logic [`OPS_RADDR_W-1:0] waddr,
    input  logic [`OPS_XLEN-1:0]    wdata
);

    logic [`OPS_XLEN-1:0] regs [`OPS_NREGS];

    // The whole array starts at zero so that every register reads zero after reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `OPS_NREGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        // Writes to x0 are dropped here as well as on the read side
        else if (we && (waddr != '0))
        begin
            regs[waddr] <= wdata;
        end
    end

    // Reads are combinational and x0 is hardwired to zero
    // A write in the same cycle is not visible here, MEM forwarding supplies it
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: src/data_forward_u.sv
`timescale 1ns/1ps
`include "operand_cfg.svh"

// Every register-writing type updates rd from one of two places
// LUI, AUIPC, I_TYPE, R_TYPE, JAL and JALR write C, which is known in EX
// LOAD writes D, which only exists once the load reaches MEM
// STORE and BRANCH never write a register
module data_forward_u (
    // Sources of the instruction in ID
    input  logic [`OPS_RADDR_W-1:0] rs1,
    input  logic [`OPS_RADDR_W-1:0] rs2,

    // Instruction in EX
    input  logic                    wr_reg_n_in_ex,
    input  logic [`OPS_RADDR_W-1:0] rs2_in_ex,
    input  logic [`OPS_RADDR_W-1:0] rd_in_ex,
    input  pipe_pkg::ir_type_e      ir_type_in_ex,

    // Instruction in MEM
    input  logic                    wr_reg_n_in_mem,
    input  logic [`OPS_RADDR_W-1:0] rd_in_mem,
    input  pipe_pkg::ir_type_e      ir_type_in_mem,

    // Operand selects for ID and the store data select for EX
    output pipe_pkg::fwd_sel_e      forward_data1,
    output pipe_pkg::fwd_sel_e      forward_data2,
    output logic                    forward_b
);

    // True when a stage with the given rd and write flag will update rs
    // x0 is never treated as updated, so it always comes from the register file
    function automatic logic updates_src(
        input logic [`OPS_RADDR_W-1:0] rs,
        input logic [`OPS_RADDR_W-1:0] rd,
        input logic                    wr_reg_n
    );
        return !wr_reg_n && (rs == rd) && (rs != '0);
    endfunction

    // Select for one ID source
    function automatic pipe_pkg::fwd_sel_e src_select(input logic [`OPS_RADDR_W-1:0] rs);
        logic by_ex;
        logic by_mem;

        by_ex  = updates_src(rs, rd_in_ex, wr_reg_n_in_ex);
        by_mem = updates_src(rs, rd_in_mem, wr_reg_n_in_mem);

        // The EX instruction is younger than the MEM one, so its value is the latest
        if (by_ex)
        begin
            // A load in EX has no data yet
            // The stall unit holds ID for a cycle and MEM forwarding picks D up then
            if (ir_type_in_ex == pipe_pkg::LOAD)
            begin
                return pipe_pkg::FWD_NONE;
            end
            return pipe_pkg::FWD_EX;
        end
        else if (by_mem)
        begin
            return pipe_pkg::FWD_MEM;
        end
        return pipe_pkg::FWD_NONE;
    endfunction

    assign forward_data1 = src_select(rs1);
    assign forward_data2 = src_select(rs2);

    // A store right behind a load of its data register gets D straight from MEM
    // This is why ID never stalls for the rs2 of a store
    assign forward_b = updates_src(rs2_in_ex, rd_in_mem, wr_reg_n_in_mem) &&
                       (ir_type_in_mem == pipe_pkg::LOAD);

endmodule

// File: src/load_use_stall.sv
`timescale 1ns/1ps
`include "operand_cfg.svh"

module load_use_stall (
    input  logic [`OPS_RADDR_W-1:0] id_rs1,
    input  logic [`OPS_RADDR_W-1:0] id_rs2,
    input  pipe_pkg::ir_type_e      id_ir_type,
    input  logic [`OPS_RADDR_W-1:0] ex_rd,
    input  logic                    ex_wr_reg_n,
    input  pipe_pkg::ir_type_e      ex_ir_type,
    output logic                    stall
);

    logic load_in_ex;
    logic uses_rs1;
    logic uses_rs2;

    // Only a load that really writes a nonzero register can cause a hazard
    assign load_in_ex = (ex_ir_type == pipe_pkg::LOAD) && !ex_wr_reg_n && (ex_rd != '0);

    // LUI, AUIPC, JAL and bubbles read no register
    assign uses_rs1 = (id_ir_type inside {pipe_pkg::I_TYPE, pipe_pkg::R_TYPE, pipe_pkg::LOAD,
                                          pipe_pkg::STORE, pipe_pkg::JALR, pipe_pkg::BRANCH});

    // The rs2 of a store is left out because forward_b covers it in EX
    assign uses_rs2 = (id_ir_type inside {pipe_pkg::R_TYPE, pipe_pkg::BRANCH});

    assign stall = load_in_ex &&
                   ((uses_rs1 && (id_rs1 == ex_rd)) || (uses_rs2 && (id_rs2 == ex_rd)));

endmodule

// File: src/id_operand_select.sv
`timescale 1ns/1ps
`include "operand_cfg.svh"

module id_operand_select (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,

    // Decoded instruction in ID
    input  logic [`OPS_RADDR_W-1:0] id_rs1,
    input  logic [`OPS_RADDR_W-1:0] id_rs2,
    input  logic [`OPS_RADDR_W-1:0] id_rd,
    input  pipe_pkg::ir_type_e      id_ir_type,
    input  logic                    id_wr_reg_n,

    // Operand sources
    input  logic [`OPS_XLEN-1:0]    rf_data1,
    input  logic [`OPS_XLEN-1:0]    rf_data2,
    input  pipe_pkg::fwd_sel_e      forward_data1,
    input  pipe_pkg::fwd_sel_e      forward_data2,
    input  logic [`OPS_XLEN-1:0]    ex_result,
    input  logic [`OPS_XLEN-1:0]    mem_wb_data,

    // ID/EX register contents
    output logic [`OPS_RADDR_W-1:0] ex_rs2,
    output logic [`OPS_RADDR_W-1:0] ex_rd,
    output pipe_pkg::ir_type_e      ex_ir_type,
    output logic                    ex_wr_reg_n,
    output logic [`OPS_XLEN-1:0]    ex_a,
    output logic [`OPS_XLEN-1:0]    ex_b
);

    logic [`OPS_XLEN-1:0] id_a;
    logic [`OPS_XLEN-1:0] id_b;

    function automatic logic [`OPS_XLEN-1:0] pick_operand(
        input pipe_pkg::fwd_sel_e   sel,
        input logic [`OPS_XLEN-1:0] rf_val
    );
        case (sel)
            pipe_pkg::FWD_EX:  return ex_result;
            pipe_pkg::FWD_MEM: return mem_wb_data;
            default:           return rf_val;
        endcase
    endfunction

    // Operands are resolved in ID so EX sees them straight from the register
    assign id_a = pick_operand(forward_data1, rf_data1);
    assign id_b = pick_operand(forward_data2, rf_data2);

    // Control fields of ID/EX
    // A stall puts a bubble into EX while ID keeps its instruction
    always_ff @(posedge clk)
    begin
        if (rst || stall)
        begin
            ex_rs2      <= '0;
            ex_rd       <= '0;
            ex_ir_type  <= pipe_pkg::NOP;
            ex_wr_reg_n <= 1'b1;
        end
        else
        begin
            ex_rs2      <= id_rs2;
            ex_rd       <= id_rd;
            ex_ir_type  <= id_ir_type;
            ex_wr_reg_n <= id_wr_reg_n;
        end
    end

    // Operand values only matter for real instructions
    always_ff @(posedge clk)
    begin
        ex_a <= id_a;
        ex_b <= id_b;
    end

endmodule

// File: src/ex_mem_stage.sv
`timescale 1ns/1ps
`include "operand_cfg.svh"

module ex_mem_stage (
    input  logic                    clk,
    input  logic                    rst,

    // Instruction in EX
    input  logic [`OPS_RADDR_W-1:0] ex_rd,
    input  pipe_pkg::ir_type_e      ex_ir_type,
    input  logic                    ex_wr_reg_n,
    input  logic [`OPS_XLEN-1:0]    ex_result,
    input  logic [`OPS_XLEN-1:0]    ex_b,
    input  logic                    forward_b,

    // Load data D of the instruction in MEM
    input  logic [`OPS_XLEN-1:0]    mem_load_data,

    output logic [`OPS_XLEN-1:0]    ex_store_data,
    output logic [`OPS_RADDR_W-1:0] mem_rd,
    output pipe_pkg::ir_type_e      mem_ir_type,
    output logic                    mem_wr_reg_n,
    output logic                    wb_en,
    output logic [`OPS_XLEN-1:0]    wb_data
);

    logic [`OPS_XLEN-1:0] mem_c;

    // Store data comes from D when the load just ahead produced it
    assign ex_store_data = forward_b ? mem_load_data : ex_b;

    // EX never stalls, so every cycle moves the EX instruction into MEM
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_rd       <= '0;
            mem_ir_type  <= pipe_pkg::NOP;
            mem_wr_reg_n <= 1'b1;
        end
        else
        begin
            mem_rd       <= ex_rd;
            mem_ir_type  <= ex_ir_type;
            mem_wr_reg_n <= ex_wr_reg_n;
        end
    end

    // C carries PC+4 for JAL and JALR as well as ALU results
    always_ff @(posedge clk)
    begin
        mem_c <= ex_result;
    end

    // MEM is the last stage, so the write-back is formed here
    assign wb_en   = !mem_wr_reg_n && (mem_rd != '0);

    // Loads write D, everything else writes C
    assign wb_data = (mem_ir_type == pipe_pkg::LOAD) ? mem_load_data : mem_c;

endmodule

// File: src/operand_supply.sv
`timescale 1ns/1ps
`include "operand_cfg.svh"

module operand_supply (
    input  logic                    clk,
    input  logic                    rst,

    // Decoded instruction in ID
    input  logic [`OPS_RADDR_W-1:0] id_rs1,
    input  logic [`OPS_RADDR_W-1:0] id_rs2,
    input  logic [`OPS_RADDR_W-1:0] id_rd,
    input  pipe_pkg::ir_type_e      id_ir_type,
    input  logic                    id_wr_reg_n,

    // C of the instruction in EX and D of the instruction in MEM
    input  logic [`OPS_XLEN-1:0]    ex_result,
    input  logic [`OPS_XLEN-1:0]    mem_load_data,

    output logic                    stall,
    output logic [`OPS_XLEN-1:0]    ex_a,
    output logic [`OPS_XLEN-1:0]    ex_b,
    output logic [`OPS_XLEN-1:0]    ex_store_data,
    output logic                    wb_en,
    output logic [`OPS_RADDR_W-1:0] wb_rd,
    output logic [`OPS_XLEN-1:0]    wb_data
);

    logic [`OPS_XLEN-1:0]    rf_data1;
    logic [`OPS_XLEN-1:0]    rf_data2;
    pipe_pkg::fwd_sel_e      forward_data1;
    pipe_pkg::fwd_sel_e      forward_data2;
    logic                    forward_b;
    logic [`OPS_RADDR_W-1:0] ex_rs2;
    logic [`OPS_RADDR_W-1:0] ex_rd;
    pipe_pkg::ir_type_e      ex_ir_type;
    logic                    ex_wr_reg_n;
    pipe_pkg::ir_type_e      mem_ir_type;
    logic                    mem_wr_reg_n;

    // Registers are read in ID and written from MEM
    reg_file reg_file_i (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (id_rs1),
        .raddr2 (id_rs2),
        .rdata1 (rf_data1),
        .rdata2 (rf_data2),
        .we     (wb_en),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    data_forward_u data_forward_u_i (
        .rs1             (id_rs1),
        .rs2             (id_rs2),
        .wr_reg_n_in_ex  (ex_wr_reg_n),
        .rs2_in_ex       (ex_rs2),
        .rd_in_ex        (ex_rd),
        .ir_type_in_ex   (ex_ir_type),
        .wr_reg_n_in_mem (mem_wr_reg_n),
        .rd_in_mem       (wb_rd),
        .ir_type_in_mem  (mem_ir_type),
        .forward_data1   (forward_data1),
        .forward_data2   (forward_data2),
        .forward_b       (forward_b)
    );

    load_use_stall load_use_stall_i (
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .id_ir_type  (id_ir_type),
        .ex_rd       (ex_rd),
        .ex_wr_reg_n (ex_wr_reg_n),
        .ex_ir_type  (ex_ir_type),
        .stall       (stall)
    );

    // The MEM forward value is the same value that is being written back
    id_operand_select id_operand_select_i (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_rd         (id_rd),
        .id_ir_type    (id_ir_type),
        .id_wr_reg_n   (id_wr_reg_n),
        .rf_data1      (rf_data1),
        .rf_data2      (rf_data2),
        .forward_data1 (forward_data1),
        .forward_data2 (forward_data2),
        .ex_result     (ex_result),
        .mem_wb_data   (wb_data),
        .ex_rs2        (ex_rs2),
        .ex_rd         (ex_rd),
        .ex_ir_type    (ex_ir_type),
        .ex_wr_reg_n   (ex_wr_reg_n),
        .ex_a          (ex_a),
        .ex_b          (ex_b)
    );

    // The MEM rd doubles as the write-back register number
    ex_mem_stage ex_mem_stage_i (
        .clk           (clk),
        .rst           (rst),
        .ex_rd         (ex_rd),
        .ex_ir_type    (ex_ir_type),
        .ex_wr_reg_n   (ex_wr_reg_n),
        .ex_result     (ex_result),
        .ex_b          (ex_b),
        .forward_b     (forward_b),
        .mem_load_data (mem_load_data),
        .ex_store_data (ex_store_data),
        .mem_rd        (wb_rd),
        .mem_ir_type   (mem_ir_type),
        .mem_wr_reg_n  (mem_wr_reg_n),
        .wb_en         (wb_en),
        .wb_data       (wb_data)
    );

endmodule

// File: testbench/operand_supply_tb.sv
`timescale 1ns/1ps
`include "operand_cfg.svh"

module operand_supply_tb;

    typedef logic [`OPS_XLEN-1:0]    data_t;
    typedef logic [`OPS_RADDR_W-1:0] raddr_t;

    localparam int RESET_CYCLES = 5;

    logic               clk;
    logic               rst;
    raddr_t             id_rs1;
    raddr_t             id_rs2;
    raddr_t             id_rd;
    pipe_pkg::ir_type_e id_ir_type;
    logic               id_wr_reg_n;
    data_t              ex_result;
    data_t              mem_load_data;
    logic               stall;
    data_t              ex_a;
    data_t              ex_b;
    data_t              ex_store_data;
    logic               wb_en;
    raddr_t             wb_rd;
    data_t              wb_data;

    // Instruction table: type, sources, destination, write flag, expected stall, constant
    pipe_pkg::ir_type_e tbl_type[$];
    int                 tbl_rs1[$];
    int                 tbl_rs2[$];
    int                 tbl_rd[$];
    logic               tbl_wrn[$];
    logic               tbl_stall[$];
    data_t              tbl_k[$];

    // Reference model of the architectural registers and of what sits in EX and MEM
    data_t              model_regs [`OPS_NREGS];
    pipe_pkg::ir_type_e m_ex_type;
    int                 m_ex_rd;
    int                 m_ex_rs2;
    logic               m_ex_wrn;
    data_t              m_ex_c;
    data_t              m_ex_a;
    data_t              m_ex_b;
    logic               m_ex_care_a;
    logic               m_ex_care_b;
    pipe_pkg::ir_type_e m_mem_type;
    int                 m_mem_rd;
    logic               m_mem_wrn;
    data_t              m_mem_c;
    data_t              m_mem_d;

    int cycles = 0;
    int limit = 1000;

    operand_supply operand_supply_i (
        .clk           (clk),
        .rst           (rst),
        .id_rs1        (id_rs1),
        .id_rs2        (id_rs2),
        .id_rd         (id_rd),
        .id_ir_type    (id_ir_type),
        .id_wr_reg_n   (id_wr_reg_n),
        .ex_result     (ex_result),
        .mem_load_data (mem_load_data),
        .stall         (stall),
        .ex_a          (ex_a),
        .ex_b          (ex_b),
        .ex_store_data (ex_store_data),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Guards against a run that never reaches the end of the table
    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= limit)
        begin
            stop_on_error($sformatf("Timeout: the table did not finish within %0d cycles", limit));
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("FAILED at %0d ns: %s is 0x%08h, expected 0x%08h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input raddr_t got, input raddr_t exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("FAILED at %0d ns: %s is x%0d, expected x%0d",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("FAILED at %0d ns: %s is %b, expected %b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_type(input string name, input pipe_pkg::ir_type_e got,
                              input pipe_pkg::ir_type_e exp);
        if (got !== exp)
        begin
            stop_on_error($sformatf("FAILED at %0d ns: %s is %s, expected %s",
                                    $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic add_row(input pipe_pkg::ir_type_e t, input int rs1, input int rs2,
                           input int rd, input int wrn, input int stl, input data_t k);
        tbl_type.push_back(t);
        tbl_rs1.push_back(rs1);
        tbl_rs2.push_back(rs2);
        tbl_rd.push_back(rd);
        tbl_wrn.push_back(wrn != 0);
        tbl_stall.push_back(stl != 0);
        tbl_k.push_back(k);
    endtask

    task automatic build_table();
        // Dependent ALU chain fed from EX and from MEM
        add_row(pipe_pkg::LUI,    0,  0,  1,  0, 0, 32'h0001_2000);
        add_row(pipe_pkg::LUI,    0,  0,  2,  0, 0, 32'h0000_0340);
        add_row(pipe_pkg::R_TYPE, 1,  2,  3,  0, 0, 32'd5);
        add_row(pipe_pkg::I_TYPE, 3,  0,  4,  0, 0, 32'd7);
        add_row(pipe_pkg::R_TYPE, 3,  4,  5,  0, 0, 32'd11);
        // x6 is written twice in a row and the younger value has to win
        add_row(pipe_pkg::I_TYPE, 5,  0,  6,  0, 0, 32'd1);
        add_row(pipe_pkg::I_TYPE, 0,  0,  6,  0, 0, 32'd9);
        add_row(pipe_pkg::R_TYPE, 6,  0,  7,  0, 0, 32'd2);
        // A write to x0 is dropped, and x0 is not forwarded from it
        add_row(pipe_pkg::I_TYPE, 5,  0,  0,  0, 0, 32'd3);
        add_row(pipe_pkg::R_TYPE, 0,  0,  8,  0, 0, 32'd4);
        // Load-use on rs1 of an R-type, rs1 of an I-type and rs2 of an R-type
        add_row(pipe_pkg::LOAD,   1,  0,  9,  0, 0, 32'h10);
        add_row(pipe_pkg::R_TYPE, 9,  2,  10, 0, 1, 32'd6);
        add_row(pipe_pkg::LOAD,   0,  0,  11, 0, 0, 32'h4);
        add_row(pipe_pkg::I_TYPE, 11, 0,  12, 0, 1, 32'd8);
        add_row(pipe_pkg::LOAD,   2,  0,  13, 0, 0, 32'h8);
        add_row(pipe_pkg::R_TYPE, 3,  13, 14, 0, 1, 32'd1);
        // Store data comes from the load ahead without a stall
        add_row(pipe_pkg::LOAD,   2,  0,  15, 0, 0, 32'hc);
        add_row(pipe_pkg::STORE,  4,  15, 0,  1, 0, 32'h20);
        // The store address register still needs the stall
        add_row(pipe_pkg::LOAD,   3,  0,  16, 0, 0, 32'h0);
        add_row(pipe_pkg::STORE,  16, 5,  0,  1, 1, 32'h4);
        // LUI ignores its rs1 field, so the load ahead causes no stall
        add_row(pipe_pkg::LOAD,   1,  0,  17, 0, 0, 32'h18);
        add_row(pipe_pkg::LUI,    17, 0,  18, 0, 0, 32'habcd_0000);
        add_row(pipe_pkg::JAL,    0,  0,  19, 0, 0, 32'h0000_0104);
        add_row(pipe_pkg::JALR,   19, 0,  20, 0, 0, 32'd4);
        add_row(pipe_pkg::BRANCH, 20, 19, 0,  1, 0, 32'd0);
        add_row(pipe_pkg::AUIPC,  0,  0,  21, 0, 0, 32'h0000_2000);
        add_row(pipe_pkg::R_TYPE, 21, 17, 22, 1, 0, 32'd1);
        add_row(pipe_pkg::NOP,    0,  0,  0,  1, 0, 32'd0);
        add_row(pipe_pkg::NOP,    0,  0,  0,  1, 0, 32'd0);
        // Read every register back once the pipeline has drained
        for (int r = 1; r < 23; r += 2)
        begin
            add_row(pipe_pkg::BRANCH, r, r + 1, 0, 1, 0, '0);
        end
        add_row(pipe_pkg::NOP,    0,  0,  0,  1, 0, 32'd0);
        add_row(pipe_pkg::NOP,    0,  0,  0,  1, 0, 32'd0);
    endtask

    function automatic logic writes_reg(input logic wrn, input int rd, input int r);
        return !wrn && (rd == r) && (r != 0);
    endfunction

    // Value that the instruction in MEM writes back
    function automatic data_t mem_value();
        return (m_mem_type == pipe_pkg::LOAD) ? m_mem_d : m_mem_c;
    endfunction

    // Newest value of register r as an instruction in ID should see it
    // Unknown while the newest writer is a load that is still in EX
    task automatic latest_value(input int r, output data_t val, output logic known);
        known = 1'b1;
        val = model_regs[r];
        if (r == 0)
        begin
            val = '0;
        end
        else if (writes_reg(m_ex_wrn, m_ex_rd, r))
        begin
            val = m_ex_c;
            known = (m_ex_type != pipe_pkg::LOAD);
        end
        else if (writes_reg(m_mem_wrn, m_mem_rd, r))
        begin
            val = mem_value();
        end
    endtask

    task automatic drive_row(input int idx);
        id_ir_type    = tbl_type[idx];
        id_rs1        = raddr_t'(tbl_rs1[idx]);
        id_rs2        = raddr_t'(tbl_rs2[idx]);
        id_rd         = raddr_t'(tbl_rd[idx]);
        id_wr_reg_n   = tbl_wrn[idx];
        ex_result     = m_ex_c;
        mem_load_data = m_mem_d;
    endtask

    task automatic check_outputs();
        data_t store_exp;

        check_type("ex_ir_type", operand_supply_i.ex_ir_type, m_ex_type);
        if (m_ex_care_a)
        begin
            check_data("ex_a", ex_a, m_ex_a);
        end
        if (m_ex_care_b)
        begin
            check_data("ex_b", ex_b, m_ex_b);
        end
        // A store right behind a load of its data register takes D
        if (m_ex_type == pipe_pkg::STORE)
        begin
            store_exp = m_ex_b;
            if ((m_mem_type == pipe_pkg::LOAD) && writes_reg(m_mem_wrn, m_mem_rd, m_ex_rs2))
            begin
                store_exp = m_mem_d;
            end
            check_data("ex_store_data", ex_store_data, store_exp);
        end
        check_bit("wb_en", wb_en, writes_reg(m_mem_wrn, m_mem_rd, m_mem_rd));
        check_addr("wb_rd", wb_rd, raddr_t'(m_mem_rd));
        if (writes_reg(m_mem_wrn, m_mem_rd, m_mem_rd))
        begin
            check_data("wb_data", wb_data, mem_value());
        end
    endtask

    // Model of one rising edge: write-back, EX into MEM, then ID or a bubble into EX
    task automatic advance_model(input int idx, input logic hold, input data_t a_val,
                                 input logic a_known, input data_t b_val, input logic b_known);
        if (writes_reg(m_mem_wrn, m_mem_rd, m_mem_rd))
        begin
            model_regs[m_mem_rd] = mem_value();
        end
        m_mem_type = m_ex_type;
        m_mem_rd   = m_ex_rd;
        m_mem_wrn  = m_ex_wrn;
        m_mem_c    = m_ex_c;
        if (m_ex_type == pipe_pkg::LOAD)
        begin
            m_mem_d = $urandom();
        end
        m_ex_type   = hold ? pipe_pkg::NOP : tbl_type[idx];
        m_ex_rd     = hold ? 0 : tbl_rd[idx];
        m_ex_rs2    = hold ? 0 : tbl_rs2[idx];
        m_ex_wrn    = hold ? 1'b1 : tbl_wrn[idx];
        m_ex_a      = a_val;
        m_ex_b      = b_val;
        m_ex_care_a = !hold && a_known;
        m_ex_care_b = !hold && b_known;
        // LUI and JAL results are the constant alone
        if (hold || !a_known || (m_ex_type inside {pipe_pkg::LUI, pipe_pkg::JAL}))
        begin
            m_ex_c = hold ? '0 : tbl_k[idx];
        end
        else
        begin
            m_ex_c = a_val + tbl_k[idx];
        end
    endtask

    initial
    begin
        int    idx;
        logic  held;
        logic  exp_stall;
        data_t a_val;
        data_t b_val;
        logic  a_known;
        logic  b_known;

        void'($urandom(75));
        build_table();
        limit = 3 * tbl_type.size() + RESET_CYCLES + 20;
        for (int r = 0; r < `OPS_NREGS; r++)
        begin
            model_regs[r] = '0;
        end
        m_ex_type   = pipe_pkg::NOP;
        m_ex_rd     = 0;
        m_ex_rs2    = 0;
        m_ex_wrn    = 1'b1;
        m_ex_c      = '0;
        m_ex_care_a = 1'b0;
        m_ex_care_b = 1'b0;
        m_mem_type  = pipe_pkg::NOP;
        m_mem_rd    = 0;
        m_mem_wrn   = 1'b1;
        m_mem_c     = '0;
        m_mem_d     = '0;
        rst = 1'b1;
        drive_row(tbl_type.size() - 1);
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        idx = 0;
        held = 1'b0;
        while (idx < tbl_type.size())
        begin
            drive_row(idx);
            #5;
            // A row that stalls does so only on its first cycle in ID
            exp_stall = tbl_stall[idx] && !held;
            check_bit("stall", stall, exp_stall);
            check_outputs();
            latest_value(tbl_rs1[idx], a_val, a_known);
            latest_value(tbl_rs2[idx], b_val, b_known);
            advance_model(idx, exp_stall, a_val, a_known, b_val, b_known);
            held = exp_stall;
            if (!exp_stall)
            begin
                idx++;
            end
            @(negedge clk);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+src
src/pipe_pkg.sv
src/reg_file.sv
src/data_forward_u.sv
src/load_use_stall.sv
src/id_operand_select.sv
src/ex_mem_stage.sv
src/operand_supply.sv
testbench/operand_supply_tb.sv

// File: Makefile
# Verilator build and run for the operand supply block

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= operand_supply_tb
RTL_TOP   ?= operand_supply
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides the result, so a failing run still leaves its log behind
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
